/* flist.f */
src/core_cfg_pkg.sv
src/riscv_priv_pkg.sv
src/updown_counter.sv
src/flush_ctrl.sv
src/fence_t_seq.sv
src/flush_unit_top.sv
test/tb_clock_gen.sv
test/tb_flush_unit.sv

/* src/core_cfg_pkg.sv */
// --------------------
// Fixed core configuration for the flush unit
// Flags select the cache type and the enabled ISA extensions
// --------------------
package core_cfg_pkg;

  // --------------------
  // Feature flags
  // --------------------
  // Data cache is write-back and needs an explicit flush
  localparam logic DCACHE_WB = 1'b1;
  // Supervisor mode, enables sfence.vma
  localparam logic RVS       = 1'b1;
  // Hypervisor, enables hfence and VS-mode TLB flushes
  localparam logic RVH       = 1'b1;
  // Atomics, commit stage may request a flush
  localparam logic RVA       = 1'b1;
  // Debug mode entry redirects the PC
  localparam logic DEBUG_EN  = 1'b1;

  // --------------------
  // Counter widths
  // --------------------
  // Drain and micro-reset windows of 16 cycles
  localparam int unsigned DRAIN_W = 4;
  // Pad and self-invalidation counters
  localparam int unsigned PAD_W   = 32;

endpackage

/* src/fence_t_seq.sv */
// --------------------
// fence.t sequencer, runs flush, drain, pad and micro-reset in order
// and provides the restart PC and the recorded pad ceiling
// --------------------
module fence_t_seq (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      fence_t_i,
  input  logic                      flush_dcache_ack_i,
  input  logic                      cache_busy_i,
  // Pad start source, 0 for timer edge, 1 for leaving U mode
  input  logic                      fence_t_src_sel_i,
  input  logic                      time_irq_i,
  input  riscv_priv_pkg::priv_lvl_e priv_lvl_i,
  input  riscv_priv_pkg::word_t     fence_t_pad_i,
  input  riscv_priv_pkg::vaddr_t    boot_addr_i,
  input  riscv_priv_pkg::vaddr_t    pc_commit_i,
  output logic                      rst_uarch_no,
  output logic                      stall_cache_o,
  output logic                      cache_init_no,
  output logic                      fence_t_busy_o,
  output riscv_priv_pkg::word_t     fence_t_ceil_o,
  output riscv_priv_pkg::vaddr_t    rst_addr_o
);

  import core_cfg_pkg::*;
  import riscv_priv_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    FLUSH_DCACHE,
    DRAIN_REQS,
    PAD,
    RST_UARCH
  } fence_t_state_e;

  fence_t_state_e state_d, state_q;

  logic [DRAIN_W-1:0] rst_cnt_d, rst_cnt_q;
  logic [DRAIN_W-1:0] drain_cnt;
  logic [PAD_W-1:0]   pad_cnt;
  logic               load_pad;
  logic               time_irq_q;
  priv_lvl_e          priv_lvl_q;
  vaddr_t             rst_addr_q;
  // Shift register stretching cache init by 3 cycles
  logic [2:0]         cache_init_d, cache_init_q;

  // --------------------
  // Sequencer FSM
  // --------------------
  always_comb begin : fsm
    state_d         = state_q;
    rst_cnt_d       = rst_cnt_q;
    rst_uarch_no    = 1'b1;
    fence_t_ceil_o  = '0;
    cache_init_d    = {cache_init_q[1:0], 1'b0};

    unique case (state_q)
      IDLE: begin
        if (fence_t_i) begin
          state_d = FLUSH_DCACHE;
        end
      end
      // Flush request itself comes from flush_ctrl
      FLUSH_DCACHE: begin
        if (flush_dcache_ack_i) begin
          state_d = DRAIN_REQS;
        end
      end
      // Cache is the only handshaked port, wait for it to stay idle
      DRAIN_REQS: begin
        if (drain_cnt == '1) begin
          state_d = PAD;
          // Cycles already used of the pad window
          if (pad_cnt != '0) begin
            fence_t_ceil_o = fence_t_pad_i - pad_cnt;
          end
        end
      end
      PAD: begin
        if (pad_cnt == '0) begin
          state_d = RST_UARCH;
        end
      end
      // 16 cycles of micro-reset
      RST_UARCH: begin
        rst_uarch_no    = 1'b0;
        cache_init_d[0] = 1'b1;
        if (rst_cnt_q == '1) begin
          rst_cnt_d = '0;
          state_d   = IDLE;
        end else begin
          rst_cnt_d = rst_cnt_q + DRAIN_W'(1);
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign fence_t_busy_o = (state_q != IDLE);
  // Cache takes no new requests for the whole sequence
  assign stall_cache_o  = fence_t_busy_o;
  assign cache_init_no  = |cache_init_q;
  assign rst_addr_o     = rst_addr_q;

  // --------------------
  // Counters
  // --------------------
  // Drain window restarts on every busy cycle and outside the drain state
  updown_counter #(
    .WIDTH (DRAIN_W)
  ) u_drain_cnt (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (cache_busy_i || (state_q != DRAIN_REQS)),
    .en_i    (drain_cnt != '1),
    .load_i  (1'b0),
    .down_i  (1'b0),
    .d_i     ('0),
    .q_o     (drain_cnt)
  );

  // Timer edge, or any step out of U mode
  assign load_pad = fence_t_src_sel_i ?
                    ((priv_lvl_q == PRIV_LVL_U) && (priv_lvl_i != PRIV_LVL_U)) :
                    (time_irq_i && !time_irq_q);

  // Pad window counts down to zero from the CSR value
  updown_counter #(
    .WIDTH (PAD_W)
  ) u_pad_cnt (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (1'b0),
    .en_i    (|pad_cnt),
    .load_i  (load_pad),
    .down_i  (1'b1),
    .d_i     (fence_t_pad_i),
    .q_o     (pad_cnt)
  );

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      rst_cnt_q    <= '0;
      cache_init_q <= '0;
      time_irq_q   <= 1'b0;
      priv_lvl_q   <= PRIV_LVL_M;
      rst_addr_q   <= boot_addr_i;
    end else begin
      state_q      <= state_d;
      rst_cnt_q    <= rst_cnt_d;
      cache_init_q <= cache_init_d;
      time_irq_q   <= time_irq_i;
      priv_lvl_q   <= priv_lvl_i;
      // Resume after the fence.t instruction
      if (fence_t_i) begin
        rst_addr_q <= pc_commit_i + vaddr_t'(4);
      end
    end
  end

endmodule

/* src/flush_ctrl.sv */
// --------------------
// Turns pipeline events into flush strobes and holds the data cache flush
// until the cache acknowledges it, also drives halt and self-invalidation
// --------------------
module flush_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Current instruction runs in VS mode
  input  logic                  v_i,
  input  logic                  mispredict_i,
  input  logic                  fence_i,
  input  logic                  fence_i_i,
  input  logic                  fence_t_i,
  input  logic                  sfence_vma_i,
  input  logic                  hfence_vvma_i,
  input  logic                  hfence_gvma_i,
  input  logic                  flush_csr_i,
  input  logic                  flush_acc_i,
  input  logic                  flush_commit_i,
  input  logic                  ex_valid_i,
  input  logic                  eret_i,
  input  logic                  set_debug_pc_i,
  // Level from the data cache, high when the flush is done
  input  logic                  flush_dcache_ack_i,
  input  logic                  halt_csr_i,
  input  logic                  halt_acc_i,
  input  logic                  fence_t_busy_i,
  input  riscv_priv_pkg::word_t selfinval_period_i,
  output logic                  set_pc_commit_o,
  output logic                  flush_if_o,
  output logic                  flush_unissued_instr_o,
  output logic                  flush_id_o,
  output logic                  flush_ex_o,
  output logic                  flush_bp_o,
  output logic                  flush_icache_o,
  output logic                  flush_tlb_o,
  output logic                  flush_tlb_vvma_o,
  output logic                  flush_tlb_gvma_o,
  output logic                  flush_dcache_o,
  output logic                  fence_active_o,
  output logic                  halt_o
);

  import core_cfg_pkg::*;

  logic             fence_active_d, fence_active_q;
  logic             flush_dcache_d, flush_dcache_q;
  logic [PAD_W-1:0] selfinval_cnt;
  logic             selfinval;

  // Qualified requests, masked by the core configuration
  logic sfence_req;
  logic hfence_vvma_req;
  logic hfence_gvma_req;
  logic commit_req;
  logic selfinval_req;
  logic dcache_req;
  logic trap_req;

  assign sfence_req      = RVS && sfence_vma_i;
  assign hfence_vvma_req = RVH && hfence_vvma_i;
  assign hfence_gvma_req = RVH && hfence_gvma_i;
  assign commit_req      = RVA && flush_commit_i;
  // Self-invalidation waits while another fence owns the cache
  assign selfinval_req   = DCACHE_WB && selfinval && !fence_active_q;
  // Exception, eret or debug entry, the front end takes a new PC
  assign trap_req        = ex_valid_i || eret_i || (DEBUG_EN && set_debug_pc_i);

  // fence.t always writes back, fence and fence.i only for a WB cache
  assign dcache_req = (DCACHE_WB && (fence_i || fence_i_i)) || fence_t_i || selfinval_req;

  // --------------------
  // Stage flush decode
  // --------------------
  always_comb begin : flush_decode
    set_pc_commit_o        = 1'b0;
    flush_if_o             = 1'b0;
    flush_unissued_instr_o = 1'b0;
    flush_id_o             = 1'b0;
    flush_ex_o             = 1'b0;
    flush_bp_o             = 1'b0;
    flush_icache_o         = 1'b0;
    flush_tlb_o            = 1'b0;
    flush_tlb_vvma_o       = 1'b0;
    flush_tlb_gvma_o       = 1'b0;

    // Mispredict only drops the front end and unissued entries
    if (mispredict_i) begin
      flush_if_o             = 1'b1;
      flush_unissued_instr_o = 1'b1;
    end

    // Fences and CSR side effects restart at the commit PC
    if (fence_i || fence_i_i || sfence_req || hfence_vvma_req || hfence_gvma_req ||
        flush_csr_i || flush_acc_i || commit_req || selfinval_req) begin
      set_pc_commit_o        = 1'b1;
      flush_if_o             = 1'b1;
      flush_unissued_instr_o = 1'b1;
      flush_id_o             = 1'b1;
      flush_ex_o             = 1'b1;
    end

    // New code may have been written, or fence.t clears all state
    if (fence_i_i || fence_t_i) begin
      flush_icache_o = 1'b1;
    end

    // sfence.vma in VS mode hits the guest translations
    if (sfence_req) begin
      if (RVH && v_i) begin
        flush_tlb_vvma_o = 1'b1;
      end else begin
        flush_tlb_o = 1'b1;
      end
    end
    if (hfence_vvma_req) begin
      flush_tlb_vvma_o = 1'b1;
    end
    if (hfence_gvma_req) begin
      flush_tlb_gvma_o = 1'b1;
    end

    // Traps win, the PC comes from the CSR file and not from commit
    if (trap_req) begin
      set_pc_commit_o        = 1'b0;
      flush_if_o             = 1'b1;
      flush_unissued_instr_o = 1'b1;
      flush_id_o             = 1'b1;
      flush_ex_o             = 1'b1;
      // Keep speculative fetches out of the new context
      flush_bp_o             = 1'b1;
    end
  end

  // --------------------
  // Data cache fence
  // --------------------
  always_comb begin : fence_next
    fence_active_d = fence_active_q;
    if (dcache_req) begin
      fence_active_d = 1'b1;
    end else if (fence_active_q && flush_dcache_ack_i) begin
      fence_active_d = 1'b0;
    end
  end

  // Request held until the acknowledge, registered toward the cache
  assign flush_dcache_d = dcache_req || (fence_active_q && !flush_dcache_ack_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fence_active_q <= 1'b0;
      flush_dcache_q <= 1'b0;
    end else begin
      fence_active_q <= fence_active_d;
      flush_dcache_q <= flush_dcache_d;
    end
  end

  assign flush_dcache_o = flush_dcache_q;
  assign fence_active_o = fence_active_q;

  // Commit stalls for WFI, the accelerator, any fence or fence.t
  assign halt_o = halt_csr_i || halt_acc_i || (DCACHE_WB && fence_active_q) || fence_t_busy_i;

  // --------------------
  // Self-invalidation
  // --------------------
  // Counts period down to zero, fires and reloads, one pulse every period+1 cycles
  assign selfinval = (selfinval_cnt == '0) && (selfinval_period_i != '0);

  updown_counter #(
    .WIDTH (PAD_W)
  ) u_selfinval_cnt (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (1'b0),
    .en_i    (|selfinval_period_i),
    .load_i  (selfinval),
    .down_i  (1'b1),
    .d_i     (selfinval_period_i),
    .q_o     (selfinval_cnt)
  );

endmodule

/* src/flush_unit_top.sv */
// --------------------
// Flush and fence control unit, joins the flush decoder and the fence.t sequencer
// --------------------
module flush_unit_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      v_i,
  input  logic                      mispredict_i,
  input  logic                      fence_i,
  input  logic                      fence_i_i,
  input  logic                      fence_t_i,
  input  logic                      sfence_vma_i,
  input  logic                      hfence_vvma_i,
  input  logic                      hfence_gvma_i,
  input  logic                      flush_csr_i,
  input  logic                      flush_acc_i,
  input  logic                      flush_commit_i,
  input  logic                      ex_valid_i,
  input  logic                      eret_i,
  input  logic                      set_debug_pc_i,
  input  logic                      flush_dcache_ack_i,
  input  logic                      halt_csr_i,
  input  logic                      halt_acc_i,
  input  riscv_priv_pkg::word_t     selfinval_period_i,
  input  logic                      cache_busy_i,
  input  logic                      fence_t_src_sel_i,
  input  logic                      time_irq_i,
  input  riscv_priv_pkg::priv_lvl_e priv_lvl_i,
  input  riscv_priv_pkg::word_t     fence_t_pad_i,
  input  riscv_priv_pkg::vaddr_t    boot_addr_i,
  input  riscv_priv_pkg::vaddr_t    pc_commit_i,
  output logic                      set_pc_commit_o,
  output logic                      flush_if_o,
  output logic                      flush_unissued_instr_o,
  output logic                      flush_id_o,
  output logic                      flush_ex_o,
  output logic                      flush_bp_o,
  output logic                      flush_icache_o,
  output logic                      flush_tlb_o,
  output logic                      flush_tlb_vvma_o,
  output logic                      flush_tlb_gvma_o,
  output logic                      flush_dcache_o,
  output logic                      fence_active_o,
  output logic                      halt_o,
  output logic                      rst_uarch_no,
  output logic                      stall_cache_o,
  output logic                      cache_init_no,
  output riscv_priv_pkg::word_t     fence_t_ceil_o,
  output riscv_priv_pkg::vaddr_t    rst_addr_o
);

  // Sequencer busy, feeds the halt combine
  logic fence_t_busy;

  flush_ctrl u_flush_ctrl (
    .fence_t_busy_i (fence_t_busy),
    .*
  );

  fence_t_seq u_fence_t_seq (
    .fence_t_busy_o (fence_t_busy),
    .*
  );

endmodule

/* src/riscv_priv_pkg.sv */
// --------------------
// Privilege levels and data widths seen by the flush unit
// --------------------
package riscv_priv_pkg;

  // Virtual address, used for boot, commit and restart PCs
  typedef logic [31:0] vaddr_t;

  // Plain 32-bit CSR value
  // Pad cycles, recorded ceiling, self-invalidation period
  typedef logic [31:0] word_t;

  // --------------------
  // Privilege levels
  // --------------------
  // Encoding 2 is reserved
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_S = 2'd1,
    PRIV_LVL_M = 2'd3
  } priv_lvl_e;

endpackage

/* src/updown_counter.sv */
// --------------------
// Loadable up/down counter with synchronous clear
// Priority is clear, then load, then count when enabled
// --------------------
module updown_counter #(
  parameter int unsigned WIDTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             en_i,
  input  logic             load_i,
  input  logic             down_i,
  input  logic [WIDTH-1:0] d_i,
  output logic [WIDTH-1:0] q_o
);

  logic [WIDTH-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clear_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= d_i;
    end else if (en_i) begin
      // Wraps silently, callers gate en_i at the limits
      if (down_i) begin
        cnt_q <= cnt_q - WIDTH'(1);
      end else begin
        cnt_q <= cnt_q + WIDTH'(1);
      end
    end
  end

  assign q_o = cnt_q;

endmodule

/* test/tb_clock_gen.sv */
// --------------------
// Testbench clock and power-on reset
// 10 ns clock, active-low reset held for the first 10 cycles
// --------------------
module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned HALF_PERIOD_NS = 5;
  localparam int unsigned RESET_CYCLES   = 10;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // Release away from the clock edge, like the other inputs
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2 rst_no = 1'b1;
  end

endmodule

/* test/tb_flush_unit.sv */
// --------------------
// Directed testbench for the flush unit, one task per behavior
// The TB plays the pipeline, the caches and the CSR file
// --------------------
module tb_flush_unit;

  timeunit 1ns;
  timeprecision 100ps;

  import riscv_priv_pkg::*;

  // --------------------
  // Run length
  // --------------------
  localparam int unsigned CLK_PERIOD_NS = 10;
  // Cycle budgets per test sized for the longest LFSR draws
  localparam int unsigned BUDGET_CYCLES = 20 + 20 + 40 + 20 + 150 + 2 * 200 + 60;
  localparam int unsigned MARGIN_CYCLES = 100;
  localparam int unsigned WATCHDOG_NS   = (BUDGET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS;

  // Idle cycles the drain window needs after a busy cycle
  localparam int unsigned DRAIN_IDLE = 15;

  // Bit masks over the strobe vector in the order of stage_flushes()
  localparam logic [9:0] M_PC    = 10'b10_0000_0000;
  localparam logic [9:0] M_STAGE = 10'b01_1110_0000;
  localparam logic [9:0] M_MISP  = 10'b01_1000_0000;
  localparam logic [9:0] M_BP    = 10'b00_0001_0000;
  localparam logic [9:0] M_IC    = 10'b00_0000_1000;
  localparam logic [9:0] M_TLB   = 10'b00_0000_0100;
  localparam logic [9:0] M_VVMA  = 10'b00_0000_0010;
  localparam logic [9:0] M_GVMA  = 10'b00_0000_0001;

  logic clk_i;
  logic rst_ni;

  logic v_i, mispredict_i, fence_i, fence_i_i, fence_t_i;
  logic sfence_vma_i, hfence_vvma_i, hfence_gvma_i;
  logic flush_csr_i, flush_acc_i, flush_commit_i;
  logic ex_valid_i, eret_i, set_debug_pc_i;
  logic flush_dcache_ack_i, halt_csr_i, halt_acc_i;
  logic cache_busy_i, fence_t_src_sel_i, time_irq_i;
  word_t     selfinval_period_i;
  word_t     fence_t_pad_i;
  priv_lvl_e priv_lvl_i;
  vaddr_t    boot_addr_i;
  vaddr_t    pc_commit_i;

  logic set_pc_commit_o, flush_if_o, flush_unissued_instr_o, flush_id_o, flush_ex_o;
  logic flush_bp_o, flush_icache_o, flush_tlb_o, flush_tlb_vvma_o, flush_tlb_gvma_o;
  logic flush_dcache_o, fence_active_o, halt_o;
  logic rst_uarch_no, stall_cache_o, cache_init_no;
  word_t  fence_t_ceil_o;
  vaddr_t rst_addr_o;

  int unsigned errors;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned cyc;
  logic [15:0] lfsr;

  tb_clock_gen u_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  flush_unit_top dut_i (.*);

  // --------------------
  // Helpers
  // --------------------
  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int unsigned n, output int unsigned v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | lfsr[0];
    end
  endtask

  function automatic logic [9:0] stage_flushes();
    return {set_pc_commit_o, flush_if_o, flush_unissued_instr_o, flush_id_o, flush_ex_o,
            flush_bp_o, flush_icache_o, flush_tlb_o, flush_tlb_vvma_o, flush_tlb_gvma_o};
  endfunction

  task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("[ERROR] %0t ns %s", $time, what);
    errors++;
  endtask

  task automatic end_test(input string name, input int unsigned errs_at_start);
    tests_run++;
    if (errors == errs_at_start) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", name, errors - errs_at_start);
    end
  endtask

  // Inputs change 2 ns after the rising edge
  task automatic tick();
    @(posedge clk_i);
    #2;
    cyc++;
  endtask

  // Cache model that acknowledges a flush in the cycle it sees it
  task automatic tick_cache();
    tick();
    flush_dcache_ack_i = flush_dcache_o;
  endtask

  task automatic wait_seq_idle();
    int unsigned n;
    n = 0;
    #1;
    while (stall_cache_o === 1'b1 && n < 64) begin
      tick();
      #1;
      n++;
    end
    if (stall_cache_o !== 1'b0) report_failure("fence.t sequence did not return to idle");
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_reset_state();
    int unsigned e0;
    e0 = errors;
    #1;
    if (stage_flushes() !== 10'b0) value_error("stage flushes", stage_flushes(), 0);
    if (flush_dcache_o !== 1'b0) value_error("flush_dcache_o", flush_dcache_o, 0);
    if (fence_active_o !== 1'b0) value_error("fence_active_o", fence_active_o, 0);
    if (halt_o !== 1'b0) value_error("halt_o", halt_o, 0);
    if (stall_cache_o !== 1'b0) value_error("stall_cache_o", stall_cache_o, 0);
    if (rst_uarch_no !== 1'b1) value_error("rst_uarch_no", rst_uarch_no, 1);
    if (cache_init_no !== 1'b0) value_error("cache_init_no", cache_init_no, 0);
    if (rst_addr_o !== boot_addr_i) value_error("rst_addr_o", rst_addr_o, boot_addr_i);
    end_test("reset state", e0);
  endtask

  task automatic test_mispredict_trap();
    int unsigned e0;
    e0 = errors;
    tick();
    mispredict_i = 1'b1;
    #1;
    if (stage_flushes() !== M_MISP) value_error("stage flushes", stage_flushes(), M_MISP);
    tick();
    mispredict_i = 1'b0;
    // Exception, eret and debug entry in turn
    for (int k = 0; k < 3; k++) begin
      ex_valid_i     = (k == 0);
      eret_i         = (k == 1);
      set_debug_pc_i = (k == 2);
      #1;
      if (stage_flushes() !== (M_STAGE | M_BP)) begin
        value_error("stage flushes", stage_flushes(), M_STAGE | M_BP);
      end
      tick();
    end
    ex_valid_i     = 1'b0;
    eret_i         = 1'b0;
    set_debug_pc_i = 1'b0;
    end_test("mispredict and traps", e0);
  endtask

  task automatic fence_case(input logic use_fence_i);
    int unsigned delay;
    logic [9:0]  exp;
    exp = M_PC | M_STAGE | (use_fence_i ? M_IC : 10'b0);
    draw_bits(3, delay);
    tick();
    fence_i   = !use_fence_i;
    fence_i_i = use_fence_i;
    #1;
    if (stage_flushes() !== exp) value_error("stage flushes", stage_flushes(), exp);
    if (flush_dcache_o !== 1'b0) value_error("flush_dcache_o", flush_dcache_o, 0);
    if (fence_active_o !== 1'b0) value_error("fence_active_o", fence_active_o, 0);
    tick();
    fence_i   = 1'b0;
    fence_i_i = 1'b0;
    #1;
    if (flush_dcache_o !== 1'b1) value_error("flush_dcache_o", flush_dcache_o, 1);
    if (fence_active_o !== 1'b1) value_error("fence_active_o", fence_active_o, 1);
    if (halt_o !== 1'b1) value_error("halt_o", halt_o, 1);
    repeat (delay) begin
      tick();
      #1;
      if (flush_dcache_o !== 1'b1) value_error("flush_dcache_o", flush_dcache_o, 1);
    end
    tick();
    flush_dcache_ack_i = 1'b1;
    #1;
    if (flush_dcache_o !== 1'b1) value_error("flush_dcache_o", flush_dcache_o, 1);
    if (fence_active_o !== 1'b1) value_error("fence_active_o", fence_active_o, 1);
    tick();
    flush_dcache_ack_i = 1'b0;
    #1;
    if (flush_dcache_o !== 1'b0) value_error("flush_dcache_o", flush_dcache_o, 0);
    if (fence_active_o !== 1'b0) value_error("fence_active_o", fence_active_o, 0);
    if (halt_o !== 1'b0) value_error("halt_o", halt_o, 0);
  endtask

  task automatic test_fence();
    int unsigned e0;
    e0 = errors;
    fence_case(1'b0);
    fence_case(1'b1);
    end_test("fence and fence.i", e0);
  endtask

  task automatic tlb_case(input int unsigned kind, input logic [9:0] exp);
    tick();
    v_i           = (kind == 1);
    sfence_vma_i  = (kind <= 1);
    hfence_vvma_i = (kind == 2);
    hfence_gvma_i = (kind == 3);
    #1;
    if (stage_flushes() !== exp) value_error("stage flushes", stage_flushes(), exp);
  endtask

  task automatic test_tlb_fence();
    int unsigned e0;
    e0 = errors;
    tlb_case(0, M_PC | M_STAGE | M_TLB);
    tlb_case(1, M_PC | M_STAGE | M_VVMA);
    tlb_case(2, M_PC | M_STAGE | M_VVMA);
    tlb_case(3, M_PC | M_STAGE | M_GVMA);
    tick();
    v_i           = 1'b0;
    sfence_vma_i  = 1'b0;
    hfence_vvma_i = 1'b0;
    hfence_gvma_i = 1'b0;
    end_test("TLB fences", e0);
  endtask

  task automatic test_fence_t();
    int unsigned e0, delay, n, low, hold;
    vaddr_t      pc;
    e0 = errors;
    draw_bits(3, delay);
    draw_bits(8, n);
    pc = 32'h8000_1000 + (n << 2);
    tick();
    fence_t_i   = 1'b1;
    pc_commit_i = pc;
    tick();
    fence_t_i = 1'b0;
    #1;
    if (rst_addr_o !== pc + 4) value_error("rst_addr_o", rst_addr_o, pc + 4);
    if (stall_cache_o !== 1'b1) value_error("stall_cache_o", stall_cache_o, 1);
    repeat (delay) tick();
    tick();
    flush_dcache_ack_i = 1'b1;
    tick();
    flush_dcache_ack_i = 1'b0;
    // A few drain cycles, then one busy cycle restarts the window
    repeat (4) tick();
    tick();
    cache_busy_i = 1'b1;
    n = 0;
    #1;
    while (rst_uarch_no === 1'b1 && n < 40) begin
      tick();
      cache_busy_i = 1'b0;
      #1;
      n++;
      if (stall_cache_o !== 1'b1) value_error("stall_cache_o", stall_cache_o, 1);
    end
    if (rst_uarch_no !== 1'b0) begin
      report_failure("micro-reset never started after fence.t");
    end else begin
      // Idle window, the saturated cycle and one PAD cycle come first
      if (n != DRAIN_IDLE + 3) value_error("cycles to rst_uarch_no", n, DRAIN_IDLE + 3);
      if (cache_init_no !== 1'b0) value_error("cache_init_no", cache_init_no, 0);
      low = 1;
      tick();
      #1;
      while (rst_uarch_no === 1'b0 && low < 40) begin
        low++;
        if (cache_init_no !== 1'b1) value_error("cache_init_no", cache_init_no, 1);
        tick();
        #1;
      end
      if (low != 16) value_error("rst_uarch_no low cycles", low, 16);
      if (stall_cache_o !== 1'b0) value_error("stall_cache_o", stall_cache_o, 0);
      if (halt_o !== 1'b0) value_error("halt_o", halt_o, 0);
      hold = 0;
      while (cache_init_no === 1'b1 && hold < 10) begin
        hold++;
        tick();
        #1;
      end
      if (hold != 3) value_error("cache_init_no hold cycles", hold, 3);
    end
    end_test("fence.t sequence", e0);
  endtask

  task automatic pad_case(input logic use_priv);
    int unsigned pad, delay, edge_cyc, ceil_cyc, n;
    word_t       ceil_val;
    logic        seen;
    draw_bits(5, pad);
    pad = pad + 40;
    draw_bits(3, delay);
    tick();
    fence_t_src_sel_i = use_priv;
    fence_t_pad_i     = pad;
    if (use_priv) priv_lvl_i = PRIV_LVL_U;
    // Load event and fence.t in the same cycle
    tick();
    fence_t_i = 1'b1;
    if (use_priv) priv_lvl_i = PRIV_LVL_M;
    else time_irq_i = 1'b1;
    edge_cyc = cyc;
    tick();
    fence_t_i  = 1'b0;
    time_irq_i = 1'b0;
    repeat (delay) tick();
    tick();
    flush_dcache_ack_i = 1'b1;
    seen     = 1'b0;
    ceil_val = '0;
    ceil_cyc = 0;
    n        = 0;
    #1;
    while (rst_uarch_no === 1'b1 && n < 150) begin
      tick();
      flush_dcache_ack_i = 1'b0;
      #1;
      n++;
      if (fence_t_ceil_o != '0) begin
        seen     = 1'b1;
        ceil_val = fence_t_ceil_o;
        ceil_cyc = cyc;
      end
    end
    if (rst_uarch_no !== 1'b0) begin
      report_failure("pad window never ended");
    end else begin
      // Pad loads after the edge cycle and counts down once per cycle
      if (!seen) report_failure("no pad ceiling pulse on the way into PAD");
      else if (ceil_val !== ceil_cyc - edge_cyc - 1) begin
        value_error("fence_t_ceil_o", ceil_val, ceil_cyc - edge_cyc - 1);
      end
      if (cyc != edge_cyc + pad + 2) begin
        value_error("micro-reset start cycle", cyc, edge_cyc + pad + 2);
      end
    end
    wait_seq_idle();
  endtask

  task automatic test_pad_ceiling();
    int unsigned e0;
    e0 = errors;
    pad_case(1'b0);
    pad_case(1'b1);
    end_test("pad and ceiling", e0);
  endtask

  task automatic test_selfinval();
    int unsigned e0, period, n;
    logic        exp_pc, exp_fl;
    e0 = errors;
    draw_bits(2, period);
    period = period + 3;
    tick_cache();
    selfinval_period_i = period;
    n = 0;
    #1;
    while (set_pc_commit_o !== 1'b1 && n < period + 2) begin
      tick_cache();
      #1;
      n++;
    end
    if (set_pc_commit_o !== 1'b1) begin
      report_failure("no self-invalidation request within one period");
    end else begin
      for (int j = 0; j < 3 * (period + 1); j++) begin
        exp_pc = (j % (period + 1)) == 0;
        exp_fl = (j % (period + 1)) == 1;
        if (set_pc_commit_o !== exp_pc) value_error("set_pc_commit_o", set_pc_commit_o, exp_pc);
        if (flush_dcache_o !== exp_fl) value_error("flush_dcache_o", flush_dcache_o, exp_fl);
        tick_cache();
        #1;
      end
    end
    tick_cache();
    selfinval_period_i = '0;
    repeat (2) tick_cache();
    for (int j = 0; j < 2 * (period + 1); j++) begin
      #1;
      if (set_pc_commit_o !== 1'b0) value_error("set_pc_commit_o", set_pc_commit_o, 0);
      if (flush_dcache_o !== 1'b0) value_error("flush_dcache_o", flush_dcache_o, 0);
      tick_cache();
    end
    flush_dcache_ack_i = 1'b0;
    end_test("self-invalidation", e0);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin : main
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cyc          = 0;
    lfsr         = 16'd25;
    {v_i, mispredict_i, fence_i, fence_i_i, fence_t_i} = '0;
    {sfence_vma_i, hfence_vvma_i, hfence_gvma_i} = '0;
    {flush_csr_i, flush_acc_i, flush_commit_i} = '0;
    {ex_valid_i, eret_i, set_debug_pc_i} = '0;
    {flush_dcache_ack_i, halt_csr_i, halt_acc_i} = '0;
    {cache_busy_i, fence_t_src_sel_i, time_irq_i} = '0;
    selfinval_period_i = '0;
    fence_t_pad_i      = '0;
    priv_lvl_i         = PRIV_LVL_M;
    boot_addr_i        = 32'h8000_0000;
    pc_commit_i        = 32'h8000_0000;
    @(posedge rst_ni);
    tick();
    test_reset_state();
    test_mispredict_trap();
    test_fence();
    test_tlb_fence();
    test_fence_t();
    test_pad_ceiling();
    test_selfinval();
    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

endmodule
